//--- Bender.yml
package:
  name: rv_slice

sources:
  - hw/rv_pkg.sv
  - hw/rv_intf.sv
  - hw/pipe_reg.sv
  - hw/inst_fetch.sv
  - hw/regfile.sv
  - hw/id_stage.sv
  - hw/ex_stage.sv
  - hw/rv_slice_top.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_rv_slice.sv

//--- bench/tb_clk_gen.sv
// testbench clock and reset

module tb_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);  // release away from the active edge
        rst_n_o = 1'b1;
    end

endmodule

//--- bench/tb_rv_slice.sv
// rv32i pipeline slice testbench

module tb_rv_slice
    import rv_pkg::*;
();

    logic                  clk;
    logic                  rst_n;
    logic [InstBus-1:0]    inst;
    logic                  inst_valid;
    logic                  stall;
    logic [RegBus-1:0]     fetch_addr;
    logic                  wb_we;
    logic [RegAddrBus-1:0] wb_waddr;
    logic [RegBus-1:0]     wb_wdata;
    logic                  jump;
    logic [RegBus-1:0]     jump_addr;

    logic [31:0] imem [0:1023];        // word-indexed instruction memory
    logic [31:0] model_regs [0:31];
    logic [31:0] prog [$];             // program under construction
    logic [36:0] exp_wb [$];           // {waddr, wdata}
    logic [31:0] exp_jmp [$];
    logic [36:0] wb_entry;
    logic [31:0] lcg_state = 32'he06a_19ca;
    int          cycles = 0;
    int          cycle_limit = 100;

    tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    rv_slice_top u_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .inst_i       (inst),
        .inst_valid_i (inst_valid),
        .stall_i      (stall),
        .fetch_addr_o (fetch_addr),
        .wb_we_o      (wb_we),
        .wb_waddr_o   (wb_waddr),
        .wb_wdata_o   (wb_wdata),
        .jump_o       (jump),
        .jump_addr_o  (jump_addr)
    );

    assign inst = imem[fetch_addr[11:2]];  // combinational memory read

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // address-dependent fence word that never writes back
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[31:7] ^ addr[24:0], INST_FENCE};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), INST_TYPE_R_M};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                          input logic [2:0] f3, input int rd, input logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input int rd,
                                          input logic [6:0] op);
        return {imm, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], INST_TYPE_B};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), INST_JAL};
    endfunction

    // rv32i integer result rules
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic is_op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [31:0] res;
        case (f3)
            3'b000: res = (is_op && alt) ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: res = (a < b) ? 32'd1 : 32'd0;
            3'b100: res = a ^ b;
            3'b101: begin
                if (alt) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            3'b111: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("[FAIL] %0t: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    // steps the program in order and predicts write-backs and redirects
    task automatic model_run(input logic [31:0] base, input int len);
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] nxt;
        logic [31:0] imm_i;
        logic        we;
        logic        jumped;
        pc = base;
        while (pc >= base && pc < base + 4 * len) begin
            w      = imem[pc[11:2]];
            a      = model_regs[w[19:15]];
            b      = model_regs[w[24:20]];
            imm_i  = {{20{w[31]}}, w[31:20]};
            nxt    = pc + 4;
            we     = 1'b1;
            jumped = 1'b0;
            res    = '0;
            case (w[6:0])
                INST_TYPE_I:   res = alu_ref(w[14:12], w[30], 1'b0, a, imm_i);
                INST_TYPE_R_M: res = alu_ref(w[14:12], w[30], 1'b1, a, b);
                INST_LUI:      res = {w[31:12], 12'h0};
                INST_AUIPC:    res = pc + {w[31:12], 12'h0};
                INST_JAL: begin
                    res    = pc + 4;
                    nxt    = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                    jumped = 1'b1;
                end
                INST_JALR: begin
                    res    = pc + 4;
                    nxt    = (a + imm_i) & ~32'h1;
                    jumped = 1'b1;
                end
                INST_TYPE_B: begin
                    we = 1'b0;
                    if (branch_ref(w[14:12], a, b)) begin
                        nxt    = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                        jumped = 1'b1;
                    end
                end
                default: we = 1'b0;
            endcase
            if (we) begin
                exp_wb.push_back({w[11:7], res});
                if (w[11:7] != 5'd0) model_regs[w[11:7]] = res;
            end
            if (jumped) exp_jmp.push_back(nxt);
            pc = nxt;
        end
    endtask

    // loads prog at the current pc and runs it until the pipeline drains
    task automatic run_prog(input bit use_stall);
        logic [31:0] base;
        logic [31:0] r;
        int          burst;
        base  = fetch_addr;
        burst = 0;
        foreach (prog[i]) imem[(base >> 2) + i] = prog[i];
        model_run(base, prog.size());
        cycle_limit += prog.size() * 4;
        do begin
            @(negedge clk);
            inst_valid = 1'b1;
            if (use_stall) begin
                r = lcg_next();
                if (burst == 0 && r[1:0] == 2'b00) burst = 1 + r[3:2];
                stall = (burst != 0);
                if (burst != 0) burst--;
            end
            @(posedge clk);
        end while (exp_wb.size() != 0 || exp_jmp.size() != 0);
        @(negedge clk);
        inst_valid = 1'b0;
        stall      = 1'b0;
        repeat (3) @(negedge clk);
        prog.delete();
    endtask

    task automatic test_reset();
        repeat (4) begin
            @(negedge clk);
            check_eq("wb_we_o", wb_we, 0);
            check_eq("jump_o", jump, 0);
            check_eq("fetch_addr_o", fetch_addr, BootAddr);
        end
        wait (rst_n);
        @(negedge clk);
        check_eq("wb_we_o", wb_we, 0);
        check_eq("jump_o", jump, 0);
        check_eq("fetch_addr_o", fetch_addr, BootAddr);
    endtask

    task automatic test_alu();
        logic [31:0] r;
        for (int k = 1; k <= 4; k++) begin  // random operands in x1..x4
            r = lcg_next();
            prog.push_back(enc_u(r[31:12], k, INST_LUI));
            prog.push_back(enc_i(r[11:0], k, INST_ADDI, k, INST_TYPE_I));
        end
        for (int k = 0; k < 8; k++) begin
            prog.push_back(enc_r(7'h00, 2, 1, 3'(k), 5 + k));
        end
        prog.push_back(enc_r(7'h20, 2, 1, INST_ADD_SUB, 13));
        prog.push_back(enc_r(7'h20, 4, 3, INST_SR, 14));
        for (int k = 0; k < 8; k++) begin
            r = lcg_next();
            if (k == 1 || k == 5) r[11:5] = 7'h00;  // plain shift amount
            prog.push_back(enc_i(r[11:0], 3, 3'(k), 15 + k, INST_TYPE_I));
        end
        r = lcg_next();
        prog.push_back(enc_i({7'h20, r[4:0]}, 4, INST_SRI, 23, INST_TYPE_I));  // srai
        run_prog(1'b0);
    endtask

    task automatic test_dep();
        logic [31:0] r;
        r = lcg_next();
        prog.push_back(enc_i(r[11:0], 0, INST_ADDI, 6, INST_TYPE_I));
        prog.push_back(enc_r(7'h00, 6, 6, INST_ADD_SUB, 6));  // distance 1
        prog.push_back(enc_r(7'h20, 1, 6, INST_ADD_SUB, 7));
        prog.push_back(enc_r(7'h00, 6, 7, INST_XOR, 6));
        prog.push_back(enc_i(12'h005, 6, INST_ADDI, 0, INST_TYPE_I));  // lands in x0
        prog.push_back(enc_r(7'h00, 6, 0, INST_ADD_SUB, 8));
        prog.push_back(enc_r(7'h00, 0, 8, INST_OR, 9));
        run_prog(1'b0);
    endtask

    task automatic test_branch();
        logic [31:0] r;
        logic [2:0]  br_f3 [6] = '{INST_BEQ, INST_BNE, INST_BLT, INST_BGE, INST_BLTU, INST_BGEU};
        int          rs1_list [3] = '{1, 2, 1};
        int          rs2_list [3] = '{2, 1, 3};
        r = lcg_next();
        prog.push_back(enc_u({1'b1, r[30:12]}, 1, INST_LUI));  // x1 negative
        r = lcg_next();
        prog.push_back(enc_u({1'b0, r[30:12]}, 2, INST_LUI));  // x2 positive
        prog.push_back(enc_i({1'b0, r[10:0]}, 2, INST_ADDI, 2, INST_TYPE_I));
        prog.push_back(enc_r(7'h00, 0, 1, INST_ADD_SUB, 3));   // x3 copy of x1
        for (int b = 0; b < 6; b++) begin
            for (int q = 0; q < 3; q++) begin
                prog.push_back(enc_b(13'd12, rs2_list[q], rs1_list[q], br_f3[b]));
                prog.push_back(enc_i(12'h001, 10, INST_ADDI, 10, INST_TYPE_I));
                prog.push_back(enc_i(12'h001, 11, INST_ADDI, 11, INST_TYPE_I));
                prog.push_back(enc_i(12'h001, 12, INST_ADDI, 12, INST_TYPE_I));
            end
        end
        run_prog(1'b0);
    endtask

    task automatic test_jump();
        logic [31:0] r;
        r = lcg_next();
        prog.push_back(enc_u(r[31:12], 5, INST_AUIPC));
        prog.push_back(enc_u(20'h0, 6, INST_AUIPC));
        prog.push_back(enc_j(21'd12, 1));
        prog.push_back(enc_i(12'h001, 0, INST_ADDI, 20, INST_TYPE_I));
        prog.push_back(enc_i(12'h001, 0, INST_ADDI, 21, INST_TYPE_I));
        prog.push_back(enc_i(12'd25, 6, 3'b000, 2, INST_JALR));  // odd offset drops bit 0
        prog.push_back(enc_i(12'h001, 0, INST_ADDI, 22, INST_TYPE_I));
        prog.push_back(enc_r(7'h00, 2, 1, INST_ADD_SUB, 23));
        run_prog(1'b0);
    endtask

    task automatic test_stall();
        logic [31:0] r;
        for (int k = 0; k < 24; k++) begin  // chain through x1..x6
            r = lcg_next();
            if (r[13:12] == 2'b01) r[11:5] = {1'b0, r[10], 5'h00};
            if (k % 3 == 2) begin
                prog.push_back(enc_r(7'h00, 1 + k % 6, 1 + (k + 5) % 6, r[14:12], 1 + k % 6));
            end else begin
                prog.push_back(enc_i(r[11:0], 1 + (k + 5) % 6, r[14:12], 1 + k % 6,
                                     INST_TYPE_I));
            end
            if (k == 11) prog.push_back(enc_b(13'd8, 0, 0, INST_BEQ));
        end
        run_prog(1'b1);
    endtask

    // write-back and redirect monitor on the falling edge
    always @(negedge clk) begin
        if (rst_n && wb_we) begin
            if (exp_wb.size() == 0) begin
                fail_stop($sformatf("unexpected write-back to x%0d at %0t", wb_waddr, $time));
            end else begin
                wb_entry = exp_wb.pop_front();
                check_eq("wb_waddr_o", 32'(wb_waddr), 32'(wb_entry[36:32]));
                check_eq("wb_wdata_o", wb_wdata, wb_entry[31:0]);
            end
        end
        if (rst_n && jump) begin
            if (exp_jmp.size() == 0) begin
                fail_stop($sformatf("unexpected jump to %h at %0t", jump_addr, $time));
            end else begin
                check_eq("jump_addr_o", jump_addr, exp_jmp.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            fail_stop($sformatf("timeout after %0d cycles, pipeline stopped making progress",
                                cycles));
        end
    end

    initial begin
        for (int i = 0; i < 1024; i++) imem[i] = fill_word(i * 4);
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
    end

    initial begin
        inst_valid = 1'b0;
        stall      = 1'b0;
        test_reset();
        test_alu();
        test_dep();
        test_branch();
        test_jump();
        test_stall();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- compile.f
hw/rv_pkg.sv
hw/rv_intf.sv
hw/pipe_reg.sv
hw/inst_fetch.sv
hw/regfile.sv
hw/id_stage.sv
hw/ex_stage.sv
hw/rv_slice_top.sv
bench/tb_clk_gen.sv
bench/tb_rv_slice.sv

//--- hw/ex_stage.sv
// execute and write-back

module ex_stage
    import rv_pkg::*;
(
    input  logic                  dec_valid_i,
    input  dec_pkt_t              dec_i,
    output logic                  ex_ready_o,
    output logic                  wb_we_o,
    output logic [RegAddrBus-1:0] wb_waddr_o,
    output logic [RegBus-1:0]     wb_wdata_o,
    output logic                  jump_o,
    output logic [RegBus-1:0]     jump_addr_o
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              alt;  // sub / sra select
    logic [4:0]        shamt;
    logic [RegBus-1:0] sum;
    logic [RegBus-1:0] link;
    logic [RegBus-1:0] alu_res;
    logic [RegBus-1:0] wdata;
    logic [RegBus-1:0] target;
    logic              br_taken;
    logic              taken;

    assign opcode = dec_i.inst[6:0];
    assign funct3 = dec_i.inst[14:12];
    assign alt    = dec_i.inst[30];
    assign shamt  = dec_i.op2[4:0];
    assign sum    = dec_i.op1 + dec_i.op2;
    assign link   = dec_i.inst_addr + RegBus'(4);

    always_comb begin : alu
        alu_res = sum;
        case (funct3)
            INST_ADD_SUB: begin
                if (opcode == INST_TYPE_R_M && alt) begin
                    alu_res = dec_i.op1 - dec_i.op2;
                end
            end
            INST_SLL:  alu_res = dec_i.op1 << shamt;
            INST_SLT:  alu_res = {{(RegBus-1){1'b0}}, $signed(dec_i.op1) < $signed(dec_i.op2)};
            INST_SLTU: alu_res = {{(RegBus-1){1'b0}}, dec_i.op1 < dec_i.op2};
            INST_XOR:  alu_res = dec_i.op1 ^ dec_i.op2;
            INST_SR: begin
                if (alt) begin
                    alu_res = $signed(dec_i.op1) >>> shamt;
                end else begin
                    alu_res = dec_i.op1 >> shamt;
                end
            end
            INST_OR:   alu_res = dec_i.op1 | dec_i.op2;
            INST_AND:  alu_res = dec_i.op1 & dec_i.op2;
        endcase
    end

    // compares the raw register values
    always_comb begin : branch_cmp
        case (funct3)
            INST_BEQ:  br_taken = dec_i.reg1_rdata == dec_i.reg2_rdata;
            INST_BNE:  br_taken = dec_i.reg1_rdata != dec_i.reg2_rdata;
            INST_BLT:  br_taken = $signed(dec_i.reg1_rdata) < $signed(dec_i.reg2_rdata);
            INST_BGE:  br_taken = $signed(dec_i.reg1_rdata) >= $signed(dec_i.reg2_rdata);
            INST_BLTU: br_taken = dec_i.reg1_rdata < dec_i.reg2_rdata;
            INST_BGEU: br_taken = dec_i.reg1_rdata >= dec_i.reg2_rdata;
            default:   br_taken = 1'b0;
        endcase
    end

    always_comb begin : result_sel
        wdata  = alu_res;  // op and op-imm
        taken  = 1'b0;
        target = sum;
        case (opcode)
            INST_LUI:   wdata = dec_i.op1;
            INST_AUIPC: wdata = sum;
            INST_JAL: begin
                wdata = link;
                taken = 1'b1;
            end
            INST_JALR: begin
                wdata  = link;
                taken  = 1'b1;
                target = {sum[RegBus-1:1], 1'b0};
            end
            INST_TYPE_B: taken = br_taken;
            default: ;
        endcase
    end

    assign ex_ready_o  = 1'b1;  // single-cycle, never backs up
    assign wb_we_o     = dec_valid_i & dec_i.reg_we;
    assign wb_waddr_o  = dec_i.reg_waddr;
    assign wb_wdata_o  = wdata;
    assign jump_o      = dec_valid_i & taken;
    assign jump_addr_o = target;

endmodule

//--- hw/id_stage.sv
// instruction decode and operand build

module id_stage
    import rv_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        ex_ready_i,
    input  logic        jump_i,
    fetch_bus.consumer  fetch_if,
    reg_rd_bus.requester rd_if,
    output logic        dec_valid_o,
    output dec_pkt_t    dec_o
);

    logic [InstBus-1:0]    inst;
    logic [RegBus-1:0]     inst_addr;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [RegAddrBus-1:0] rd;
    logic [RegAddrBus-1:0] rs1;
    logic [RegAddrBus-1:0] rs2;
    logic [RegBus-1:0]     imm_i;
    logic [RegBus-1:0]     imm_b;
    logic [RegBus-1:0]     imm_j;
    logic [RegBus-1:0]     imm_u;
    logic                  reg_we;
    logic [RegAddrBus-1:0] reg_waddr;
    logic [RegAddrBus-1:0] raddr1;
    logic [RegAddrBus-1:0] raddr2;
    logic [RegBus-1:0]     op1;
    logic [RegBus-1:0]     op2;
    dec_pkt_t              dec_d;
    logic                  en;
    logic                  clear;

    assign inst      = fetch_if.pkt.inst;
    assign inst_addr = fetch_if.pkt.inst_addr;
    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign funct7    = inst[31:25];
    assign rd        = inst[11:7];
    assign rs1       = inst[19:15];
    assign rs2       = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    // handshake with execute, empty slot becomes a bubble
    assign en             = ex_ready_i & fetch_if.valid;
    assign clear          = jump_i | (ex_ready_i & ~fetch_if.valid);
    assign fetch_if.ready = ex_ready_i;
    assign fetch_if.clear = clear;

    always_comb begin : decode_ctrl
        reg_we    = 1'b0;
        reg_waddr = '0;
        raddr1    = '0;
        raddr2    = '0;
        case (opcode)
            INST_TYPE_I: begin
                case (funct3)
                    INST_ADDI, INST_SLTI, INST_SLTIU, INST_XORI,
                    INST_ORI, INST_ANDI, INST_SLLI, INST_SRI: begin
                        reg_we    = 1'b1;
                        reg_waddr = rd;
                        raddr1    = rs1;
                    end
                    default: ;
                endcase
            end
            INST_TYPE_R_M: begin
                if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin  // no mul/div
                    reg_we    = 1'b1;
                    reg_waddr = rd;
                    raddr1    = rs1;
                    raddr2    = rs2;
                end
            end
            INST_TYPE_B: begin
                case (funct3)
                    INST_BEQ, INST_BNE, INST_BLT, INST_BGE, INST_BLTU, INST_BGEU: begin
                        raddr1 = rs1;
                        raddr2 = rs2;
                    end
                    default: ;
                endcase
            end
            INST_JALR: begin
                reg_we    = 1'b1;
                reg_waddr = rd;
                raddr1    = rs1;
            end
            INST_JAL, INST_LUI, INST_AUIPC: begin
                reg_we    = 1'b1;
                reg_waddr = rd;
            end
            INST_FENCE: ;  // nothing to order here
            default: ;
        endcase
    end

    assign rd_if.raddr1 = raddr1;
    assign rd_if.raddr2 = raddr2;

    always_comb begin : operands
        op1 = '0;
        op2 = '0;
        case (opcode)
            INST_TYPE_I: begin
                op1 = rd_if.rdata1;
                op2 = imm_i;
            end
            INST_TYPE_R_M: begin
                op1 = rd_if.rdata1;
                op2 = rd_if.rdata2;
            end
            INST_TYPE_B: begin  // target base, compare uses rdata
                op1 = inst_addr;
                op2 = imm_b;
            end
            INST_JAL: begin
                op1 = inst_addr;
                op2 = imm_j;
            end
            INST_JALR: begin
                op1 = rd_if.rdata1;
                op2 = imm_i;
            end
            INST_LUI:   op1 = imm_u;
            INST_AUIPC: begin
                op1 = inst_addr;
                op2 = imm_u;
            end
            default: ;
        endcase
    end

    assign dec_d = '{inst:       inst,
                     inst_addr:  inst_addr,
                     op1:        op1,
                     op2:        op2,
                     reg1_rdata: rd_if.rdata1,
                     reg2_rdata: rd_if.rdata2,
                     reg_we:     reg_we,
                     reg_waddr:  reg_waddr};

    pipe_reg #(.T(dec_pkt_t), .RST_VAL(DecBubble)) u_dec_reg (
        .clk_i,
        .rst_n_i,
        .en_i    (en),
        .clear_i (clear),
        .d_i     (dec_d),
        .q_o     (dec_o)
    );

    pipe_reg #(.T(logic), .RST_VAL(1'b0)) u_valid_reg (
        .clk_i,
        .rst_n_i,
        .en_i    (en),
        .clear_i (clear),
        .d_i     (fetch_if.valid),
        .q_o     (dec_valid_o)
    );

endmodule

//--- hw/inst_fetch.sv
// instruction fetch

module inst_fetch
    import rv_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic [InstBus-1:0] inst_i,
    input  logic               inst_valid_i,
    input  logic               stall_i,
    input  logic               jump_i,
    input  logic [RegBus-1:0]  jump_addr_i,
    output logic [RegBus-1:0]  fetch_addr_o,
    fetch_bus.producer         fetch_if
);

    logic [RegBus-1:0] pc_q;
    logic              accept;
    fetch_pkt_t        pkt_d;

    // word at pc is taken this cycle
    assign accept       = inst_valid_i & ~stall_i & fetch_if.ready;
    assign fetch_addr_o = pc_q;
    assign pkt_d        = '{inst: inst_i, inst_addr: pc_q};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= BootAddr;
        end else if (jump_i) begin
            pc_q <= jump_addr_i;
        end else if (accept) begin
            pc_q <= pc_q + RegBus'(4);
        end
    end

    // a live slot dropped by decode can only be a jump kill
    pipe_reg #(.T(fetch_pkt_t), .RST_VAL(FetchBubble)) u_pkt_reg (
        .clk_i,
        .rst_n_i,
        .en_i    (accept),
        .clear_i (fetch_if.clear & fetch_if.valid),
        .d_i     (pkt_d),
        .q_o     (fetch_if.pkt)
    );

    pipe_reg #(.T(logic), .RST_VAL(1'b0)) u_valid_reg (
        .clk_i,
        .rst_n_i,
        .en_i    (fetch_if.ready),
        .clear_i (jump_i),  // wrong-path fetch
        .d_i     (accept),
        .q_o     (fetch_if.valid)
    );

endmodule

//--- hw/pipe_reg.sv
// pipeline register with enable and clear

module pipe_reg #(
    parameter type T       = logic,
    parameter T    RST_VAL = '0
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic en_i,
    input  logic clear_i,
    input  T     d_i,
    output T     q_o
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_o <= RST_VAL;
        end else if (clear_i) begin  // flush beats a load
            q_o <= RST_VAL;
        end else if (en_i) begin
            q_o <= d_i;
        end
    end

endmodule

//--- hw/regfile.sv
// integer register file

module regfile
    import rv_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  we_i,
    input  logic [RegAddrBus-1:0] waddr_i,
    input  logic [RegBus-1:0]     wdata_i,
    reg_rd_bus.responder          rd_if
);

    logic [RegBus-1:0] regs_q [1:2**RegAddrBus-1];  // x0 has no storage

    // same-cycle write is forwarded to the reader
    function automatic logic [RegBus-1:0] read_port(input logic [RegAddrBus-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we_i && addr == waddr_i) begin
            return wdata_i;
        end
        return regs_q[addr];
    endfunction

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 2**RegAddrBus; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rd_if.rdata1 = read_port(rd_if.raddr1);
        rd_if.rdata2 = read_port(rd_if.raddr2);
    end

endmodule

//--- hw/rv_intf.sv
// stage buses

// fetch register to decode
interface fetch_bus
    import rv_pkg::*;
();
    logic       valid;
    fetch_pkt_t pkt;
    logic       ready;
    logic       clear;  // decode drops the offered slot

    modport producer (output valid, output pkt, input ready, input clear);
    modport consumer (input valid, input pkt, output ready, output clear);
endinterface

// decode to register file, combinational read
interface reg_rd_bus
    import rv_pkg::*;
();
    logic [RegAddrBus-1:0] raddr1;
    logic [RegAddrBus-1:0] raddr2;
    logic [RegBus-1:0]     rdata1;
    logic [RegBus-1:0]     rdata2;

    modport requester (output raddr1, output raddr2, input rdata1, input rdata2);
    modport responder (input raddr1, input raddr2, output rdata1, output rdata2);
endinterface

//--- hw/rv_pkg.sv
// shared widths, encodings and payloads
// for the rv32i pipeline slice

package rv_pkg;

    localparam int InstBus    = 32;
    localparam int RegBus     = 32;
    localparam int RegAddrBus = 5;

    localparam logic [RegBus-1:0]  BootAddr = 32'h0;
    localparam logic [InstBus-1:0] InstNop  = 32'h0000_0013;  // addi x0, x0, 0

    // major opcodes
    localparam logic [6:0] INST_TYPE_I   = 7'b0010011;
    localparam logic [6:0] INST_TYPE_R_M = 7'b0110011;
    localparam logic [6:0] INST_TYPE_B   = 7'b1100011;
    localparam logic [6:0] INST_JAL      = 7'b1101111;
    localparam logic [6:0] INST_JALR     = 7'b1100111;
    localparam logic [6:0] INST_LUI      = 7'b0110111;
    localparam logic [6:0] INST_AUIPC    = 7'b0010111;
    localparam logic [6:0] INST_FENCE    = 7'b0001111;

    // op-imm funct3
    localparam logic [2:0] INST_ADDI  = 3'b000;
    localparam logic [2:0] INST_SLLI  = 3'b001;
    localparam logic [2:0] INST_SLTI  = 3'b010;
    localparam logic [2:0] INST_SLTIU = 3'b011;
    localparam logic [2:0] INST_XORI  = 3'b100;
    localparam logic [2:0] INST_SRI   = 3'b101;
    localparam logic [2:0] INST_ORI   = 3'b110;
    localparam logic [2:0] INST_ANDI  = 3'b111;

    // op funct3
    localparam logic [2:0] INST_ADD_SUB = 3'b000;
    localparam logic [2:0] INST_SLL     = 3'b001;
    localparam logic [2:0] INST_SLT     = 3'b010;
    localparam logic [2:0] INST_SLTU    = 3'b011;
    localparam logic [2:0] INST_XOR     = 3'b100;
    localparam logic [2:0] INST_SR      = 3'b101;
    localparam logic [2:0] INST_OR      = 3'b110;
    localparam logic [2:0] INST_AND     = 3'b111;

    // branch funct3
    localparam logic [2:0] INST_BEQ  = 3'b000;
    localparam logic [2:0] INST_BNE  = 3'b001;
    localparam logic [2:0] INST_BLT  = 3'b100;
    localparam logic [2:0] INST_BGE  = 3'b101;
    localparam logic [2:0] INST_BLTU = 3'b110;
    localparam logic [2:0] INST_BGEU = 3'b111;

    typedef struct packed {
        logic [InstBus-1:0] inst;
        logic [RegBus-1:0]  inst_addr;
    } fetch_pkt_t;

    typedef struct packed {
        logic [InstBus-1:0]    inst;
        logic [RegBus-1:0]     inst_addr;
        logic [RegBus-1:0]     op1;
        logic [RegBus-1:0]     op2;
        logic [RegBus-1:0]     reg1_rdata;
        logic [RegBus-1:0]     reg2_rdata;
        logic                  reg_we;
        logic [RegAddrBus-1:0] reg_waddr;
    } dec_pkt_t;

    // bubbles loaded by reset and clear
    localparam fetch_pkt_t FetchBubble = '{inst: InstNop, inst_addr: BootAddr};
    localparam dec_pkt_t   DecBubble   = '{inst: InstNop, default: '0};

endpackage

//--- hw/rv_slice_top.sv
// rv32i pipeline slice, top level

module rv_slice_top
    import rv_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [InstBus-1:0]    inst_i,
    input  logic                  inst_valid_i,
    input  logic                  stall_i,
    output logic [RegBus-1:0]     fetch_addr_o,
    output logic                  wb_we_o,
    output logic [RegAddrBus-1:0] wb_waddr_o,
    output logic [RegBus-1:0]     wb_wdata_o,
    output logic                  jump_o,
    output logic [RegBus-1:0]     jump_addr_o
);

    logic     ex_ready;
    logic     dec_valid;
    dec_pkt_t dec;

    fetch_bus  u_fetch_bus ();
    reg_rd_bus u_rd_bus ();

    inst_fetch u_fetch (
        .clk_i,
        .rst_n_i,
        .inst_i,
        .inst_valid_i,
        .stall_i,
        .jump_i       (jump_o),
        .jump_addr_i  (jump_addr_o),
        .fetch_addr_o,
        .fetch_if     (u_fetch_bus.producer)
    );

    regfile u_regfile (
        .clk_i,
        .rst_n_i,
        .we_i    (wb_we_o),  // write-back commits here
        .waddr_i (wb_waddr_o),
        .wdata_i (wb_wdata_o),
        .rd_if   (u_rd_bus.responder)
    );

    id_stage u_id (
        .clk_i,
        .rst_n_i,
        .ex_ready_i  (ex_ready),
        .jump_i      (jump_o),
        .fetch_if    (u_fetch_bus.consumer),
        .rd_if       (u_rd_bus.requester),
        .dec_valid_o (dec_valid),
        .dec_o       (dec)
    );

    ex_stage u_ex (
        .dec_valid_i (dec_valid),
        .dec_i       (dec),
        .ex_ready_o  (ex_ready),
        .wb_we_o,
        .wb_waddr_o,
        .wb_wdata_o,
        .jump_o,
        .jump_addr_o
    );

endmodule
